// File: design/alu_execute.sv
module alu_execute (
	input logic clock,
	input logic reset,
	input logic execute_en,
	input pdp_pkg::alu_op_t alu_op,
	input logic byte_op,
	input pdp_pkg::word_t src_value,
	input pdp_pkg::word_t dst_value,
	input pdp_pkg::flags_t flags_in,
	output pdp_pkg::word_t result,
	output pdp_pkg::flags_t next_flags
);

	// byte operands ride in the upper byte, so sign is always bit 15
	// and carry is always bit 16
	pdp_pkg::word_t a, b, lsb, keep, max_pos, res;
	logic [16:0] wide;
	logic cin, c_new, v_new, shift_op;
	pdp_pkg::flags_t f;

	assign a = byte_op ? {dst_value[7:0], 8'h00} : dst_value;
	assign b = byte_op ? {src_value[7:0], 8'h00} : src_value;
	assign lsb = byte_op ? 16'h0100 : 16'h0001;
	assign keep = byte_op ? 16'hff00 : 16'hffff;
	assign max_pos = byte_op ? 16'h7f00 : 16'h7fff;
	assign cin = flags_in.c;

	always_comb
	begin
		wide = '0;
		c_new = cin;
		v_new = 1'b0;
		shift_op = 1'b0;
		case (alu_op)
			pdp_pkg::op_clr: c_new = 1'b0;
			pdp_pkg::op_com:
			begin
				wide = {1'b0, ~a & keep};
				c_new = 1'b1;
			end
			pdp_pkg::op_inc:
			begin
				wide = {1'b0, a + lsb};
				v_new = (wide[15:0] == 16'h8000);
			end
			pdp_pkg::op_dec:
			begin
				wide = {1'b0, a - lsb};
				v_new = (wide[15:0] == max_pos);
			end
			pdp_pkg::op_neg:
			begin
				wide = 17'd0 - {1'b0, a};
				v_new = (wide[15:0] == 16'h8000);
				c_new = (wide[15:0] != 16'h0000);
			end
			pdp_pkg::op_adc:
			begin
				wide = {1'b0, a} + {1'b0, cin ? lsb : 16'h0000};
				v_new = (wide[15:0] == 16'h8000) && cin;
				c_new = wide[16];
			end
			pdp_pkg::op_sbc:
			begin
				wide = {1'b0, a} - {1'b0, cin ? lsb : 16'h0000};
				v_new = (wide[15:0] == max_pos) && cin;
				c_new = wide[16];
			end
			pdp_pkg::op_tst:
			begin
				wide = {1'b0, a};
				c_new = 1'b0;
			end
			pdp_pkg::op_ror:
			begin
				wide = {1'b0, {cin, a[15:1]} & keep};
				c_new = |(a & lsb);
				shift_op = 1'b1;
			end
			pdp_pkg::op_rol:
			begin
				wide = {1'b0, {a[14:0], 1'b0} | (cin ? lsb : 16'h0000)};
				c_new = a[15];
				shift_op = 1'b1;
			end
			pdp_pkg::op_asr:
			begin
				wide = {1'b0, {a[15], a[15:1]} & keep};
				c_new = |(a & lsb);
				shift_op = 1'b1;
			end
			pdp_pkg::op_asl:
			begin
				wide = {1'b0, a[14:0], 1'b0};
				c_new = a[15];
				shift_op = 1'b1;
			end
			pdp_pkg::op_swab:
			begin
				wide = {1'b0, a[7:0], a[15:8]};
				c_new = 1'b0;
			end
			pdp_pkg::op_mov: wide = {1'b0, b};
			pdp_pkg::op_bit: wide = {1'b0, a & b};
			pdp_pkg::op_bic: wide = {1'b0, a & ~b};
			pdp_pkg::op_bis: wide = {1'b0, a | b};
			pdp_pkg::op_xor: wide = {1'b0, a ^ b};
			pdp_pkg::op_add:
			begin
				wide = {1'b0, a} + {1'b0, b};
				v_new = (a[15] == b[15]) && (wide[15] != a[15]);
				c_new = wide[16];
			end
			pdp_pkg::op_sub:
			begin
				wide = {1'b0, a} - {1'b0, b};
				v_new = (a[15] != b[15]) && (wide[15] == b[15]);
				c_new = wide[16];
			end
			pdp_pkg::op_cmp:
			begin
				// source minus destination
				wide = {1'b0, b} - {1'b0, a};
				v_new = (a[15] != b[15]) && (wide[15] == a[15]);
				c_new = wide[16];
			end
			default: wide = '0;
		endcase
		res = wide[15:0];
		f.n = res[15];
		f.z = (res == 16'h0000);
		f.c = c_new;
		f.v = shift_op ? (res[15] ^ c_new) : v_new;
		if (alu_op == pdp_pkg::op_swab)
		begin
			f.n = res[7];
			f.z = (res[7:0] == 8'h00);
		end
		if (alu_op == pdp_pkg::op_nop)
		begin
			f = flags_in;
		end
	end

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
		begin
			result <= '0;
			next_flags <= '0;
		end
		else if (execute_en)
		begin
			// byte results come back down to the low byte
			result <= byte_op ? {8'h00, res[15:8]} : res;
			next_flags <= f;
		end
	end

endmodule

// File: design/instruction_decoder.sv
module instruction_decoder (
	input logic clock,
	input logic reset,
	input logic latch_en,
	input pdp_pkg::word_t instr_word,
	output pdp_pkg::alu_op_t alu_op,
	output logic byte_op,
	output pdp_pkg::reg_index_t src_reg,
	output pdp_pkg::reg_index_t dst_reg,
	output logic write_dst
);

	pdp_pkg::word_t ir;
	logic dst_reg_mode, src_reg_mode;

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
		begin
			ir <= '0;
		end
		else if (latch_en)
		begin
			ir <= instr_word;
		end
	end

	assign dst_reg_mode = (ir[5:3] == 3'd0);
	assign src_reg_mode = (ir[11:9] == 3'd0);
	assign src_reg = ir[8:6];
	assign dst_reg = ir[2:0];

	always_comb
	begin
		alu_op = pdp_pkg::op_nop;
		byte_op = 1'b0;
		if (ir[14:11] == pdp_pkg::single_op_prefix && dst_reg_mode)
		begin
			byte_op = ir[15];
			case (ir[10:6])
				pdp_pkg::sop_clr: alu_op = pdp_pkg::op_clr;
				pdp_pkg::sop_com: alu_op = pdp_pkg::op_com;
				pdp_pkg::sop_inc: alu_op = pdp_pkg::op_inc;
				pdp_pkg::sop_dec: alu_op = pdp_pkg::op_dec;
				pdp_pkg::sop_neg: alu_op = pdp_pkg::op_neg;
				pdp_pkg::sop_adc: alu_op = pdp_pkg::op_adc;
				pdp_pkg::sop_sbc: alu_op = pdp_pkg::op_sbc;
				pdp_pkg::sop_tst: alu_op = pdp_pkg::op_tst;
				pdp_pkg::sop_ror: alu_op = pdp_pkg::op_ror;
				pdp_pkg::sop_rol: alu_op = pdp_pkg::op_rol;
				pdp_pkg::sop_asr: alu_op = pdp_pkg::op_asr;
				pdp_pkg::sop_asl: alu_op = pdp_pkg::op_asl;
				default: alu_op = pdp_pkg::op_nop;
			endcase
		end
		else if (ir[15:6] == pdp_pkg::swab_code && dst_reg_mode)
		begin
			alu_op = pdp_pkg::op_swab;
		end
		else if (ir[15:9] == pdp_pkg::xor_code && dst_reg_mode)
		begin
			alu_op = pdp_pkg::op_xor;
		end
		else if (ir[15:12] == pdp_pkg::sub_code && src_reg_mode && dst_reg_mode)
		begin
			alu_op = pdp_pkg::op_sub;
		end
		else if (src_reg_mode && dst_reg_mode)
		begin
			byte_op = ir[15];
			case (ir[14:12])
				pdp_pkg::dop_mov: alu_op = pdp_pkg::op_mov;
				pdp_pkg::dop_cmp: alu_op = pdp_pkg::op_cmp;
				pdp_pkg::dop_bit: alu_op = pdp_pkg::op_bit;
				pdp_pkg::dop_bic: alu_op = pdp_pkg::op_bic;
				pdp_pkg::dop_bis: alu_op = pdp_pkg::op_bis;
				// bit 15 is clear here since sub is decoded above
				pdp_pkg::dop_add: alu_op = pdp_pkg::op_add;
				default: alu_op = pdp_pkg::op_nop;
			endcase
		end
		if (alu_op == pdp_pkg::op_nop)
		begin
			byte_op = 1'b0;
		end
	end

	assign write_dst = !(alu_op inside {pdp_pkg::op_tst, pdp_pkg::op_cmp,
		pdp_pkg::op_bit, pdp_pkg::op_nop});

endmodule

// File: design/pdp_core_top.sv
module pdp_core_top (
	input logic clock,
	input logic reset,
	input logic load_valid,
	input pdp_pkg::store_addr_t load_addr,
	input logic [7:0] load_byte,
	input logic start,
	input pdp_pkg::store_addr_t pc_start,
	input pdp_pkg::store_addr_t pc_end,
	input pdp_pkg::reg_index_t reg_sel,
	output pdp_pkg::word_t reg_value,
	output pdp_pkg::flags_t flags,
	output logic done
);

	pdp_pkg::store_addr_t pc;
	pdp_pkg::word_t instr_word, src_value, dst_value, result;
	pdp_pkg::alu_op_t alu_op;
	pdp_pkg::reg_index_t src_reg, dst_reg;
	pdp_pkg::flags_t next_flags;
	logic accept_load, execute_en, commit_en, latch_en, init_regs;
	logic byte_op, write_dst;

	program_store store_i (
		.clock(clock), .load_valid(load_valid), .load_addr(load_addr),
		.load_byte(load_byte), .accept_load(accept_load), .read_addr(pc),
		.instr_word(instr_word)
	);

	run_sequencer seq_i (
		.clock(clock), .reset(reset), .start(start), .pc_start(pc_start),
		.pc_end(pc_end), .pc(pc), .accept_load(accept_load), .execute_en(execute_en),
		.commit_en(commit_en), .latch_en(latch_en), .init_regs(init_regs), .done(done)
	);

	instruction_decoder dec_i (
		.clock(clock), .reset(reset), .latch_en(latch_en), .instr_word(instr_word),
		.alu_op(alu_op), .byte_op(byte_op), .src_reg(src_reg), .dst_reg(dst_reg),
		.write_dst(write_dst)
	);

	alu_execute alu_i (
		.clock(clock), .reset(reset), .execute_en(execute_en), .alu_op(alu_op),
		.byte_op(byte_op), .src_value(src_value), .dst_value(dst_value),
		.flags_in(flags), .result(result), .next_flags(next_flags)
	);

	register_writeback regs_i (
		.clock(clock), .reset(reset), .init_regs(init_regs), .commit_en(commit_en),
		.write_dst(write_dst), .byte_op(byte_op), .dst_reg(dst_reg), .src_reg(src_reg),
		.result(result), .next_flags(next_flags), .src_value(src_value),
		.dst_value(dst_value), .reg_sel(reg_sel), .reg_value(reg_value), .flags(flags)
	);

endmodule

// File: design/pdp_pkg.sv
package pdp_pkg;

	localparam int word_width = 16;
	localparam int addr_width = 10;
	localparam int store_bytes = 1024;
	localparam int reg_count = 8;
	localparam int reg_index_width = 3;

	typedef logic [word_width-1:0] word_t;
	typedef logic [addr_width-1:0] store_addr_t;
	typedef logic [reg_index_width-1:0] reg_index_t;

	typedef struct packed
	{
		logic n;
		logic z;
		logic v;
		logic c;
	} flags_t;

	// r0..r5 start with fixed octal values, r6 and r7 with zero
	localparam word_t reg_reset_values [reg_count] = '{
		16'o000014, 16'o000002, 16'o000004, 16'o000012,
		16'o000010, 16'o000020, 16'o000000, 16'o000000
	};

	typedef enum logic [2:0]
	{
		st_idle,
		st_fetch,
		st_decode,
		st_execute,
		st_writeback,
		st_check,
		st_done
	} run_state_t;

	typedef enum logic [5:0]
	{
		op_nop,
		op_clr, op_com, op_inc, op_dec, op_neg, op_adc, op_sbc,
		op_tst, op_ror, op_rol, op_asr, op_asl, op_swab,
		op_mov, op_cmp, op_bit, op_bic, op_bis, op_add, op_sub,
		op_xor
	} alu_op_t;

	// bits 14..11 of every single-operand instruction except swab
	localparam logic [3:0] single_op_prefix = 4'b0001;

	// single-operand codes in bits 10..6
	localparam logic [4:0] sop_clr = 5'd8;
	localparam logic [4:0] sop_com = 5'd9;
	localparam logic [4:0] sop_inc = 5'd10;
	localparam logic [4:0] sop_dec = 5'd11;
	localparam logic [4:0] sop_neg = 5'd12;
	localparam logic [4:0] sop_adc = 5'd13;
	localparam logic [4:0] sop_sbc = 5'd14;
	localparam logic [4:0] sop_tst = 5'd15;
	localparam logic [4:0] sop_ror = 5'd16;
	localparam logic [4:0] sop_rol = 5'd17;
	localparam logic [4:0] sop_asr = 5'd18;
	localparam logic [4:0] sop_asl = 5'd19;

	// swab is 0003dd, so bits 15..6 alone identify it
	localparam logic [9:0] swab_code = 10'o0003;

	// double-operand codes in bits 14..12
	localparam logic [2:0] dop_mov = 3'd1;
	localparam logic [2:0] dop_cmp = 3'd2;
	localparam logic [2:0] dop_bit = 3'd3;
	localparam logic [2:0] dop_bic = 3'd4;
	localparam logic [2:0] dop_bis = 3'd5;
	localparam logic [2:0] dop_add = 3'd6;

	localparam logic [3:0] sub_code = 4'o16;
	localparam logic [6:0] xor_code = 7'o074;

endpackage

// File: design/program_store.sv
module program_store (
	input logic clock,
	input logic load_valid,
	input pdp_pkg::store_addr_t load_addr,
	input logic [7:0] load_byte,
	input logic accept_load,
	input pdp_pkg::store_addr_t read_addr,
	output pdp_pkg::word_t instr_word
);

	logic [7:0] mem [pdp_pkg::store_bytes];
	pdp_pkg::store_addr_t low_addr;

	// low byte of the word sits at the next address
	assign low_addr = read_addr + pdp_pkg::store_addr_t'(1);

	always_ff @(posedge clock)
	begin
		if (load_valid && accept_load)
		begin
			mem[load_addr] <= load_byte;
		end
	end

	// big-endian word, one cycle behind the address
	always_ff @(posedge clock)
	begin
		instr_word <= {mem[read_addr], mem[low_addr]};
	end

endmodule

// File: design/register_writeback.sv
module register_writeback (
	input logic clock,
	input logic reset,
	input logic init_regs,
	input logic commit_en,
	input logic write_dst,
	input logic byte_op,
	input pdp_pkg::reg_index_t dst_reg,
	input pdp_pkg::reg_index_t src_reg,
	input pdp_pkg::word_t result,
	input pdp_pkg::flags_t next_flags,
	output pdp_pkg::word_t src_value,
	output pdp_pkg::word_t dst_value,
	input pdp_pkg::reg_index_t reg_sel,
	output pdp_pkg::word_t reg_value,
	output pdp_pkg::flags_t flags
);

	pdp_pkg::word_t regs [pdp_pkg::reg_count];

	assign src_value = regs[src_reg];
	assign dst_value = regs[dst_reg];
	assign reg_value = regs[reg_sel];

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
		begin
			regs <= pdp_pkg::reg_reset_values;
			flags <= '0;
		end
		else if (init_regs)
		begin
			regs <= pdp_pkg::reg_reset_values;
			flags <= '0;
		end
		else if (commit_en)
		begin
			flags <= next_flags;
			if (write_dst && byte_op)
			begin
				// byte ops keep the high byte
				regs[dst_reg][7:0] <= result[7:0];
			end
			else if (write_dst)
			begin
				regs[dst_reg] <= result;
			end
		end
	end

endmodule

// File: design/run_sequencer.sv
module run_sequencer (
	input logic clock,
	input logic reset,
	input logic start,
	input pdp_pkg::store_addr_t pc_start,
	input pdp_pkg::store_addr_t pc_end,
	output pdp_pkg::store_addr_t pc,
	output logic accept_load,
	output logic execute_en,
	output logic commit_en,
	output logic latch_en,
	output logic init_regs,
	output logic done
);

	pdp_pkg::run_state_t state, next_state;
	pdp_pkg::store_addr_t end_addr;

	assign accept_load = (state == pdp_pkg::st_idle) || (state == pdp_pkg::st_done);
	assign init_regs = start && accept_load;
	assign latch_en = (state == pdp_pkg::st_decode);
	assign execute_en = (state == pdp_pkg::st_execute);
	assign commit_en = (state == pdp_pkg::st_writeback);
	assign done = (state == pdp_pkg::st_done);

	always_comb
	begin
		next_state = state;
		case (state)
			pdp_pkg::st_idle,
			pdp_pkg::st_done:
			begin
				if (start)
				begin
					next_state = pdp_pkg::st_fetch;
				end
			end
			pdp_pkg::st_fetch: next_state = pdp_pkg::st_decode;
			pdp_pkg::st_decode: next_state = pdp_pkg::st_execute;
			pdp_pkg::st_execute: next_state = pdp_pkg::st_writeback;
			pdp_pkg::st_writeback: next_state = pdp_pkg::st_check;
			pdp_pkg::st_check:
			begin
				// pc already points past the instruction just run
				next_state = (pc >= end_addr) ? pdp_pkg::st_done : pdp_pkg::st_fetch;
			end
			default: next_state = pdp_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
		begin
			state <= pdp_pkg::st_idle;
			pc <= '0;
			end_addr <= '0;
		end
		else
		begin
			state <= next_state;
			if (init_regs)
			begin
				pc <= pc_start;
				end_addr <= pc_end;
			end
			else if (commit_en)
			begin
				pc <= pc + pdp_pkg::store_addr_t'(2);
			end
		end
	end

endmodule

// File: flist.f
+incdir+include
design/pdp_pkg.sv
design/program_store.sv
design/run_sequencer.sv
design/instruction_decoder.sv
design/alu_execute.sv
design/register_writeback.sv
design/pdp_core_top.sv
sim/tb_pdp_core.sv

// File: include/pdp_model.svh
`ifndef PDP_MODEL_SVH
`define PDP_MODEL_SVH

typedef struct
{
	pdp_pkg::word_t regs [pdp_pkg::reg_count];
	pdp_pkg::flags_t f;
} model_t;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic pdp_pkg::word_t enc_single(logic b, logic [4:0] code, logic [2:0] dr);
	return {b, pdp_pkg::single_op_prefix, code, 3'd0, dr};
endfunction

function automatic pdp_pkg::word_t enc_double(logic [3:0] op, logic [2:0] sr, logic [2:0] dr);
	return {op, 3'd0, sr, 3'd0, dr};
endfunction

function automatic pdp_pkg::word_t enc_xor(logic [2:0] sr, logic [2:0] dr);
	return {pdp_pkg::xor_code, sr, 3'd0, dr};
endfunction

function automatic model_t model_step(model_t s, pdp_pkg::word_t ir);
	logic [16:0] m, sb, d, x, r;
	logic b, cin, c, v, wr, sh, sw, ok, dm, sm;
	int dr;
	dr = ir[2:0];
	dm = (ir[5:3] == 0);
	sm = (ir[11:9] == 0);
	cin = s.f.c;
	c = cin;
	v = 0;
	wr = 1;
	sh = 0;
	sw = 0;
	r = 0;
	ok = dm;
	// sub has bit 15 set but works on whole words
	b = ir[15] && (ir[15:12] != 4'o16);
	m = b ? 17'hff : 17'hffff;
	sb = b ? 17'h80 : 17'h8000;
	d = s.regs[dr] & m;
	x = s.regs[ir[8:6]] & m;
	if (ir[14:11] == pdp_pkg::single_op_prefix)
	begin
		case (ir[10:6])
			8: c = 0;
			9:
			begin
				r = ~d & m;
				c = 1;
			end
			10:
			begin
				r = (d + 1) & m;
				v = (r == sb);
			end
			11:
			begin
				r = (d - 1) & m;
				v = (r == sb - 1);
			end
			12:
			begin
				r = (0 - d) & m;
				v = (r == sb);
				c = (r != 0);
			end
			13:
			begin
				r = d + cin;
				c = (r > m);
				r &= m;
				v = (r == sb) && cin;
			end
			14:
			begin
				c = (d < cin);
				r = (d - cin) & m;
				v = (r == sb - 1) && cin;
			end
			15:
			begin
				r = d;
				c = 0;
				v = 0;
				wr = 0;
			end
			16:
			begin
				r = (d >> 1) | (cin ? sb : 0);
				c = d[0];
				sh = 1;
			end
			17:
			begin
				r = ((d << 1) & m) | cin;
				c = ((d & sb) != 0);
				sh = 1;
			end
			18:
			begin
				r = (d >> 1) | (d & sb);
				c = d[0];
				sh = 1;
			end
			19:
			begin
				r = (d << 1) & m;
				c = ((d & sb) != 0);
				sh = 1;
			end
			default: ok = 0;
		endcase
	end
	else if (ir[15:6] == pdp_pkg::swab_code)
	begin
		r = {d[7:0], d[15:8]};
		c = 0;
		sw = 1;
	end
	else if (ir[15:9] == pdp_pkg::xor_code)
		r = x ^ d;
	else if (!sm || ir[14:12] == 0 || ir[14:12] == 7)
		ok = 0;
	else
	begin
		case (ir[14:12])
			1: r = x;
			2:
			begin
				r = (x - d) & m;
				c = (x < d);
				wr = 0;
				v = ((x & sb) != (d & sb)) && ((r & sb) == (d & sb));
			end
			3:
			begin
				r = x & d;
				wr = 0;
			end
			4: r = d & ~x & m;
			5: r = d | x;
			default:
			begin
				if (ir[15])
				begin
					r = (d - x) & m;
					c = (d < x);
					v = ((x & sb) != (d & sb)) && ((r & sb) == (x & sb));
				end
				else
				begin
					r = d + x;
					c = (r > m);
					r &= m;
					v = ((x & sb) == (d & sb)) && ((r & sb) != (d & sb));
				end
			end
		endcase
	end
	if (!ok)
		return s;
	if (sw)
	begin
		m = 17'hff;
		sb = 17'h80;
	end
	s.f.n = ((r & sb) != 0);
	s.f.z = ((r & m) == 0);
	s.f.c = c;
	s.f.v = sh ? (s.f.n ^ c) : v;
	if (wr && b)
		s.regs[dr][7:0] = r[7:0];
	else if (wr)
		s.regs[dr] = r[15:0];
	return s;
endfunction

`endif

// File: include/pdp_model_run.svh
`ifndef PDP_MODEL_RUN_SVH
`define PDP_MODEL_RUN_SVH

// runs one program as the core does, at least one instruction
function automatic model_t model_run(const ref logic [7:0] mem [pdp_pkg::store_bytes],
	input pdp_pkg::store_addr_t pc_start, input pdp_pkg::store_addr_t pc_end);
	model_t s;
	pdp_pkg::store_addr_t pc;
	s.regs = pdp_pkg::reg_reset_values;
	s.f = '0;
	pc = pc_start;
	do
	begin
		s = model_step(s, {mem[pc], mem[pc + pdp_pkg::store_addr_t'(1)]});
		pc = pc + pdp_pkg::store_addr_t'(2);
	end
	while (pc < pc_end);
	return s;
endfunction

`endif

// File: sim/tb_pdp_core.sv
module tb_pdp_core;
	timeunit 1ns;
	timeprecision 100ps;

	`include "pdp_model.svh"
	`include "pdp_model_run.svh"

	logic clock;
	logic reset;
	logic load_valid;
	pdp_pkg::store_addr_t load_addr;
	logic [7:0] load_byte;
	logic start;
	pdp_pkg::store_addr_t pc_start;
	pdp_pkg::store_addr_t pc_end;
	pdp_pkg::reg_index_t reg_sel;
	pdp_pkg::word_t reg_value;
	pdp_pkg::flags_t flags;
	logic done;

	// byte image of what was loaded into the program store
	logic [7:0] image [pdp_pkg::store_bytes];
	logic [31:0] lfsr_state;
	pdp_pkg::word_t prog [$];

	// r0..r7 after reset, octal
	localparam pdp_pkg::word_t reset_regs [8] = '{
		16'o14, 16'o2, 16'o4, 16'o12, 16'o10, 16'o20, 16'o0, 16'o0
	};

	pdp_core_top dut_i (
		.clock(clock), .reset(reset), .load_valid(load_valid), .load_addr(load_addr),
		.load_byte(load_byte), .start(start), .pc_start(pc_start), .pc_end(pc_end),
		.reg_sel(reg_sel), .reg_value(reg_value), .flags(flags), .done(done)
	);

	initial
	begin
		clock = 1'b0;
	end

	always #4 clock = ~clock;

	task automatic stop_on_failure();
		$display("tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(pdp_pkg::word_t got, pdp_pkg::word_t exp, string what);
		if (got !== exp)
		begin
			$display("Fail %0t: %s is %o, expected %o", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_flags(pdp_pkg::flags_t got, pdp_pkg::flags_t exp, string what);
		if (got !== exp)
		begin
			$display("Fail %0t: %s nzvc is %b, expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_level(logic got, logic exp, string what);
		if (got !== exp)
		begin
			$display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_count(int got, int exp, string what);
		if (got != exp)
		begin
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// clr..asl in word or byte form, or swab
	function automatic pdp_pkg::word_t single_instr();
		logic [3:0] pick;
		logic [2:0] dr;
		logic b;
		pick = 4'(take_bits(4) % 13);
		dr = 3'(take_bits(3));
		b = 1'(take_bits(1));
		if (pick == 4'd12)
			return {pdp_pkg::swab_code, 3'd0, dr};
		else
			return enc_single(b, 5'(8 + pick), dr);
	endfunction

	// mov..bis with byte forms, add, sub and xor
	function automatic pdp_pkg::word_t double_instr();
		logic [2:0] pick;
		logic [2:0] sr;
		logic [2:0] dr;
		logic b;
		pdp_pkg::word_t w;
		pick = 3'(take_bits(3));
		sr = 3'(take_bits(3));
		dr = 3'(take_bits(3));
		b = 1'(take_bits(1));
		case (pick)
			3'd5: w = enc_double(4'o06, sr, dr);
			3'd6: w = enc_double(4'o16, sr, dr);
			3'd7: w = enc_xor(sr, dr);
			default: w = enc_double({b, pick + 3'd1}, sr, dr);
		endcase
		return w;
	endfunction

	// words the core treats as no-ops
	function automatic pdp_pkg::word_t dropped_instr();
		logic [1:0] pick;
		logic [2:0] mode;
		pdp_pkg::word_t w;
		pick = 2'(take_bits(2));
		case (pick)
			2'd0:
			begin
				// kept opcode with a memory mode on the destination
				w = take_bits(1) ? single_instr() : double_instr();
				mode = 3'(take_bits(3));
				if (mode == 3'd0)
					mode = 3'd2;
				w[5:3] = mode;
			end
			2'd1: w = {7'o070, 3'(take_bits(3)), 3'd0, 3'(take_bits(3))};
			2'd2: w = {7'o071, 3'(take_bits(3)), 3'd0, 3'(take_bits(3))};
			default: w = {1'(take_bits(1)), 4'b0000, 3'(take_bits(3)) | 3'd1, 8'(take_bits(8))};
		endcase
		return w;
	endfunction

	// kind 0 single-operand, 1 double-operand, 2 mixed with no-ops
	task automatic make_program(int kind, int n);
		logic [1:0] pick;
		prog.delete();
		for (int i = 0; i < n; i++)
		begin
			pick = (kind == 2) ? 2'(take_bits(2)) : 2'(kind);
			case (pick)
				2'd0: prog.push_back(single_instr());
				2'd1: prog.push_back(double_instr());
				default: prog.push_back(dropped_instr());
			endcase
		end
	endtask

	task automatic write_byte(pdp_pkg::store_addr_t addr, logic [7:0] value);
		@(posedge clock);
		load_valid <= 1'b1;
		load_addr <= addr;
		load_byte <= value;
		image[addr] = value;
	endtask

	task automatic load_program(pdp_pkg::store_addr_t base);
		pdp_pkg::store_addr_t a;
		for (int i = 0; i < prog.size(); i++)
		begin
			a = base + pdp_pkg::store_addr_t'(2 * i);
			write_byte(a, prog[i][15:8]);
			write_byte(a + pdp_pkg::store_addr_t'(1), prog[i][7:0]);
		end
		@(posedge clock);
		load_valid <= 1'b0;
	endtask

	// start a run, time it, then compare every register and the flags
	task automatic run_program(pdp_pkg::store_addr_t first, pdp_pkg::store_addr_t last,
		int count, bit disturb);
		int cycles;
		bit seen;
		model_t exp;
		@(posedge clock);
		reg_sel <= 3'd0;
		start <= 1'b1;
		pc_start <= first;
		pc_end <= last;
		@(posedge clock);
		start <= 1'b0;
		cycles = 0;
		seen = 0;
		while (!seen && cycles < 5 * count + 20)
		begin
			@(negedge clock);
			cycles++;
			if (cycles == 1)
			begin
				check_word(reg_value, reset_regs[0], "r0 after start");
				check_flags(flags, '0, "flags after start");
			end
			if (done)
				seen = 1;
			else
			begin
				@(posedge clock);
				if (disturb && cycles < 5 * count)
				begin
					// these writes must not reach the store
					load_valid <= 1'b1;
					load_addr <= first + pdp_pkg::store_addr_t'(take_bits(5));
					load_byte <= 8'(take_bits(8));
				end
				else
					load_valid <= 1'b0;
			end
		end
		if (!seen)
		begin
			$display("timeout: done never rose within %0d cycles of start", cycles);
			stop_on_failure();
		end
		else
		begin
			check_count(cycles, 5 * count + 1, "cycles from start to done");
			exp = model_run(image, first, last);
			for (int r = 0; r < 8; r++)
			begin
				@(posedge clock);
				reg_sel <= 3'(r);
				@(negedge clock);
				check_word(reg_value, exp.regs[r], $sformatf("r%0d", r));
			end
			check_flags(flags, exp.f, "flags");
		end
	endtask

	task automatic random_run(int kind, bit disturb);
		pdp_pkg::store_addr_t base;
		int n;
		base = pdp_pkg::store_addr_t'(2 * take_bits(8));
		n = 4 + int'(take_bits(4));
		make_program(kind, n);
		load_program(base);
		run_program(base, base + pdp_pkg::store_addr_t'(2 * n), n, disturb);
	endtask

	initial
	begin
		lfsr_state = 32'hb41454b9;
		reset <= 1'b1;
		load_valid <= 1'b0;
		load_addr <= '0;
		load_byte <= '0;
		start <= 1'b0;
		pc_start <= '0;
		pc_end <= '0;
		reg_sel <= '0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;

		// state straight out of reset
		@(negedge clock);
		check_level(done, 1'b0, "done after reset");
		check_flags(flags, '0, "flags after reset");
		for (int r = 0; r < 8; r++)
		begin
			@(posedge clock);
			reg_sel <= 3'(r);
			@(negedge clock);
			check_word(reg_value, reset_regs[r], $sformatf("r%0d after reset", r));
		end

		for (int t = 0; t < 6; t++)
			random_run(0, 0);
		for (int t = 0; t < 6; t++)
			random_run(1, 0);
		for (int t = 0; t < 6; t++)
			random_run(2, 0);

		// loads while running, and an end address at the start address
		for (int t = 0; t < 3; t++)
			random_run(2, 1);
		make_program(2, 3);
		load_program(10'd600);
		run_program(10'd600, 10'd600, 1, 0);

		// same program twice, no reset in between
		make_program(2, 12);
		load_program(10'd700);
		run_program(10'd700, 10'd724, 12, 0);
		run_program(10'd700, 10'd724, 12, 0);

		$display("all tests passed");
		$finish;
	end

endmodule
